// ==== logic/memTypesPkg.sv ====
`default_nettype none

// Types and sizes shared by the bus, the translator and the memory
package memTypesPkg;

  // Memory is 16 pages of 256 bytes, one 32-bit word per entry
  localparam int memWords = 1024;

  // Number of translated pages, one table entry each
  localparam int pageCount = 16;

  // Byte lanes in a bus word
  localparam int laneCount = 4;

  // Cycles from acceptance of memReq to memReady
  localparam int waitStates = 2;

  // Counter wide enough to reach waitStates
  localparam int waitCntW = $clog2(waitStates + 1);

  // Address word, seen flat by the ports and split by the translator
  typedef union packed {
    logic [31:0] word;
    struct packed {
      // Not decoded by the memory
      logic [19:0] upper;
      logic [3:0]  page;
      // Byte within the page
      logic [7:0]  offset;
    } fields;
  } memAddrT;

  // One page-table entry
  typedef struct packed {
    logic       valid;
    logic [3:0] physPage;
  } pageEntryT;

  // Current bus owner, ownNone while the bus is idle
  typedef enum logic [1:0] {ownNone, ownFetch, ownData} ownerT;

endpackage

`default_nettype wire

// ==== logic/coprocRegPkg.sv ====
`default_nettype none

// Coprocessor register map for the MMU control port
package coprocRegPkg;

  // Control register, holds the MMU enable
  localparam logic [3:0] cpRegControl = 4'd1;

  // Index of the page-table entry seen through cpRegTableEntry
  localparam logic [3:0] cpRegTableIndex = 4'd2;

  // Window onto the page-table entry at the current index
  localparam logic [3:0] cpRegTableEntry = 4'd3;

  // Bit positions in the control register
  localparam logic [3:0] ctrlMmuEnable = 4'd0;

endpackage

`default_nettype wire

// ==== logic/busArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module busArbiter import memTypesPkg::*; (
  input  logic  clk,
  input  logic  rstN,
  input  logic  fetchReq,
  input  logic  dataReq,
  input  logic  pageFault,
  input  logic  memReady,
  output ownerT owner,
  output logic  capture,
  output logic  memReq,
  output logic  fetchReady,
  output logic  dataReady,
  output logic  prefetchAbort,
  output logic  dataAbort
);

  // Held owner, ownNone means the FSM is idle
  ownerT ownerReg;
  // Set once memReq has gone out, so translate vs wait
  logic  inWait;
  ownerT grant;
  logic  idle;
  logic  translating;
  logic  waiting;
  logic  done;
  logic  fault;

  // Data port wins, as the memory stage would stall fetch
  assign grant = dataReq ? ownData : (fetchReq ? ownFetch : ownNone);

  assign idle        = (ownerReg == ownNone);
  assign translating = !idle && !inWait;
  assign waiting     = !idle && inWait;

  // During the grant cycle the mux already follows the new owner
  assign owner   = idle ? grant : ownerReg;
  // Translator samples the granted address at the end of the grant cycle
  assign capture = idle && (grant != ownNone);

  // Request held from good translation until memReady
  assign memReq = (translating && !pageFault) || waiting;

  // Fault ends the transfer right away, memory is never touched
  assign fault = translating && pageFault;
  assign done  = fault || (waiting && memReady);

  // Only the owner sees its ready and abort
  assign fetchReady    = done && (ownerReg == ownFetch);
  assign dataReady     = done && (ownerReg == ownData);
  assign prefetchAbort = fault && (ownerReg == ownFetch);
  assign dataAbort     = fault && (ownerReg == ownData);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ownerReg <= ownNone;
      inWait   <= 1'b0;
    end else if (idle) begin
      ownerReg <= grant;
      inWait   <= 1'b0;
    end else if (translating) begin
      // Fault returns to idle, otherwise wait for memory
      if (pageFault)
        ownerReg <= ownNone;
      else
        inWait <= 1'b1;
    end else if (memReady) begin
      // Back to idle for one cycle before the next grant
      ownerReg <= ownNone;
      inWait   <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/pageTranslator.sv ====
`timescale 1ns/1ps
`default_nettype none

module pageTranslator import memTypesPkg::*; (
  input  logic                        clk,
  input  logic                        rstN,
  input  memAddrT                     virtAddr,
  input  logic                        mmuEnable,
  input  pageEntryT [pageCount-1:0]   pageTable,
  input  logic                        capture,
  output memAddrT                     physAddr,
  output logic                        pageFault
);

  // Table read index straight from the virtual page field
  logic [3:0] tableIdx;
  pageEntryT  entry;
  memAddrT    nextPhys;
  logic       nextFault;

  assign tableIdx = virtAddr.fields.page;
  assign entry    = pageTable[tableIdx];

  always_comb begin
    // MMU off means identity, no faults possible
    nextPhys  = virtAddr;
    nextFault = 1'b0;
    if (mmuEnable) begin
      // Swap in the physical page, keep upper and offset
      nextPhys.fields.page = entry.physPage;
      nextFault            = !entry.valid;
    end
  end

  // Fault flag is control state
  always_ff @(posedge clk) begin
    if (!rstN)
      pageFault <= 1'b0;
    else if (capture)
      pageFault <= nextFault;
  end

  // Held through the wait states even if the table is rewritten
  always_ff @(posedge clk) begin
    if (capture)
      physAddr <= nextPhys;
  end

endmodule

`default_nettype wire

// ==== logic/coprocRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module coprocRegs import memTypesPkg::*, coprocRegPkg::*; (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      cpWrEn,
  input  logic [3:0]                cpAddr,
  input  logic [31:0]               cpWdata,
  output logic [31:0]               cpRdata,
  output logic                      mmuEnable,
  output pageEntryT [pageCount-1:0] pageTable
);

  // Selects which entry cpRegTableEntry reads and writes
  logic [3:0] tableIndex;

  // Register writes land on the next rising edge
  always_ff @(posedge clk) begin
    if (!rstN) begin
      mmuEnable  <= 1'b0;
      tableIndex <= '0;
      // Every entry starts invalid
      pageTable  <= '0;
    end else if (cpWrEn) begin
      case (cpAddr)
        cpRegControl: begin
          mmuEnable <= cpWdata[ctrlMmuEnable];
        end
        cpRegTableIndex: begin
          tableIndex <= cpWdata[3:0];
        end
        cpRegTableEntry: begin
          // Low bits are valid and physical page
          pageTable[tableIndex] <= pageEntryT'(cpWdata[$bits(pageEntryT)-1:0]);
        end
        default: begin
        end
      endcase
    end
  end

  // Combinational read, zero-extended
  always_comb begin
    cpRdata = '0;
    case (cpAddr)
      cpRegControl:    cpRdata[ctrlMmuEnable] = mmuEnable;
      cpRegTableIndex: cpRdata[3:0] = tableIndex;
      cpRegTableEntry: cpRdata[$bits(pageEntryT)-1:0] = pageTable[tableIndex];
      // Unknown numbers read zero
      default:         cpRdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/waitStateMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module waitStateMemory import memTypesPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 memReq,
  input  logic                 memWrite,
  input  memAddrT              memAddr,
  input  logic [31:0]          memWdata,
  input  logic [laneCount-1:0] memMask,
  output logic [31:0]          memRdata,
  output logic                 memReady
);

  logic [31:0]         mem [memWords];
  // Access in flight
  logic                busy;
  logic [waitCntW-1:0] cnt;
  logic [9:0]          wordIdx;

  // Page and offset give the word, byte bits ignored
  assign wordIdx = {memAddr.fields.page, memAddr.fields.offset[7:2]};

  // Ready after exactly waitStates cycles from acceptance
  assign memReady = busy && (cnt == waitCntW'(waitStates));

  // Read data only matters in the ready cycle
  assign memRdata = mem[wordIdx];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else if (!busy) begin
      // Accept on the rising request
      if (memReq) begin
        busy <= 1'b1;
        cnt  <= waitCntW'(1);
      end
    end else if (memReady) begin
      busy <= 1'b0;
      cnt  <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Byte-lane write in the ready cycle
  always_ff @(posedge clk) begin
    if (memReady && memWrite) begin
      for (int lane = 0; lane < laneCount; lane++) begin
        if (memMask[lane])
          mem[wordIdx][lane*8 +: 8] <= memWdata[lane*8 +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/memSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystem import memTypesPkg::*; (
  input  logic                 clk,
  input  logic                 rstN,
  // Fetch port
  input  logic                 fetchReq,
  input  logic [31:0]          fetchAddr,
  output logic                 fetchReady,
  output logic [31:0]          fetchData,
  output logic                 prefetchAbort,
  // Data port
  input  logic                 dataReq,
  input  logic                 dataWrite,
  input  logic [31:0]          dataAddr,
  input  logic [31:0]          dataWdata,
  input  logic [laneCount-1:0] dataMask,
  output logic                 dataReady,
  output logic [31:0]          dataRdata,
  output logic                 dataAbort,
  // Coprocessor port
  input  logic                 cpWrEn,
  input  logic [3:0]           cpAddr,
  input  logic [31:0]          cpWdata,
  output logic [31:0]          cpRdata
);

  ownerT                     owner;
  logic                      capture;
  logic                      memReq;
  logic                      memReady;
  logic                      memWrite;
  logic [31:0]               memRdata;
  logic                      pageFault;
  logic                      mmuEnable;
  pageEntryT [pageCount-1:0] pageTable;
  memAddrT                   virtAddr;
  memAddrT                   physAddr;

  // Owner steers its address into the translator
  assign virtAddr = (owner == ownData) ? dataAddr : fetchAddr;

  // Fetches never write
  assign memWrite = (owner == ownData) && dataWrite;

  // One read bus, each port samples it on its own ready
  assign fetchData = memRdata;
  assign dataRdata = memRdata;

  busArbiter arbiter (
    .clk(clk), .rstN(rstN),
    .fetchReq(fetchReq), .dataReq(dataReq),
    .pageFault(pageFault), .memReady(memReady),
    .owner(owner), .capture(capture), .memReq(memReq),
    .fetchReady(fetchReady), .dataReady(dataReady),
    .prefetchAbort(prefetchAbort), .dataAbort(dataAbort)
  );

  pageTranslator translator (
    .clk(clk), .rstN(rstN), .virtAddr(virtAddr),
    .mmuEnable(mmuEnable), .pageTable(pageTable), .capture(capture),
    .physAddr(physAddr), .pageFault(pageFault)
  );

  coprocRegs cpRegs (
    .clk(clk), .rstN(rstN), .cpWrEn(cpWrEn), .cpAddr(cpAddr),
    .cpWdata(cpWdata), .cpRdata(cpRdata),
    .mmuEnable(mmuEnable), .pageTable(pageTable)
  );

  // Memory sees only the translated address
  waitStateMemory memory (
    .clk(clk), .rstN(rstN), .memReq(memReq), .memWrite(memWrite),
    .memAddr(physAddr), .memWdata(dataWdata), .memMask(dataMask),
    .memRdata(memRdata), .memReady(memReady)
  );

endmodule

`default_nettype wire

// ==== test/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Free-running 8 ns clock and a synchronous reset pulse
module clockGen (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Low across the first two rising edges, released mid-cycle
  initial begin
    rstN = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/memChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Watches port completions and coprocessor reads against the driver's expectations
module memChecker (
  input  logic        clk,
  input  logic        fetchReady,
  input  logic [31:0] fetchData,
  input  logic        prefetchAbort,
  input  logic        dataReady,
  input  logic [31:0] dataRdata,
  input  logic        dataAbort,
  input  logic [31:0] cpRdata,
  // Expected values, held by the driver while each access is open
  input  logic        fetchExpect,
  input  logic [31:0] fetchExpData,
  input  logic        fetchExpAbort,
  input  logic        dataExpect,
  input  logic        dataExpRead,
  input  logic [31:0] dataExpData,
  input  logic        dataExpAbort,
  input  logic        cpExpect,
  input  logic [31:0] cpExpData,
  output int          errors
);

  initial errors = 0;

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic reportFailure(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
  endtask

  // Sampled at the rising edge, so the ready cycle's values are seen
  always @(posedge clk) begin
    if (fetchReady) begin
      if (!fetchExpect) begin
        reportFailure("fetchReady pulsed with no fetch pending");
      end else begin
        // Data side must be finished first when both ask together
        if (dataExpect)
          reportFailure("fetch completed while a data access was still pending");
        compareValue("prefetchAbort", 32'(prefetchAbort), 32'(fetchExpAbort));
        if (!fetchExpAbort)
          compareValue("fetchData", fetchData, fetchExpData);
      end
    end
    if (dataReady) begin
      if (!dataExpect) begin
        reportFailure("dataReady pulsed with no data access pending");
      end else begin
        compareValue("dataAbort", 32'(dataAbort), 32'(dataExpAbort));
        // Write completions carry no read data
        if (dataExpRead)
          compareValue("dataRdata", dataRdata, dataExpData);
      end
    end
    if (cpExpect)
      compareValue("cpRdata", cpRdata, cpExpData);
  end

endmodule

`default_nettype wire

// ==== test/memSubsystemTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb import coprocRegPkg::*; ();

  typedef enum {opCpWrite, opCpRead, opFetch, opDataRead, opDataWrite, opBoth} opT;

  // Cp rows: addr is the register number, data the written or expected value
  // Both rows: addr goes to the data port, data is the fetch address
  typedef struct packed {
    opT          op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic        expAbort;
  } rowT;

  localparam int rowCount   = 32;
  localparam int cycleLimit = rowCount * 8 + 20;

  logic        clk;
  logic        rstN;
  logic        fetchReq;
  logic [31:0] fetchAddr;
  logic        fetchReady;
  logic [31:0] fetchData;
  logic        prefetchAbort;
  logic        dataReq;
  logic        dataWrite;
  logic [31:0] dataAddr;
  logic [31:0] dataWdata;
  logic [3:0]  dataMask;
  logic        dataReady;
  logic [31:0] dataRdata;
  logic        dataAbort;
  logic        cpWrEn;
  logic [3:0]  cpAddr;
  logic [31:0] cpWdata;
  logic [31:0] cpRdata;
  // Expectations handed to the checker
  logic        fetchExpect;
  logic [31:0] fetchExpData;
  logic        fetchExpAbort;
  logic        dataExpect;
  logic        dataExpRead;
  logic [31:0] dataExpData;
  logic        dataExpAbort;
  logic        cpExpect;
  logic [31:0] cpExpData;
  int          errors;
  // Reference model of memory contents and MMU state
  logic [31:0] shadow [1024];
  logic        mmuOn;
  logic [3:0]  tableIdx;
  logic [3:0]  pageMap [16];
  integer      seed = 81;
  int          cycles = 0;
  rowT         stim [rowCount];

  clockGen clocks (.clk(clk), .rstN(rstN));

  memSubsystem u_memSubsystem (.*);

  memChecker chk (.*);

  // Word reached by an access, through the modelled page table
  function automatic logic [9:0] physWord(input logic [31:0] addr);
    logic [3:0] page;
    page = addr[11:8];
    if (mmuOn)
      page = pageMap[page];
    return {page, addr[7:2]};
  endfunction

  task automatic trackCpWrite(input logic [3:0] regNum, input logic [31:0] value);
    case (regNum)
      cpRegControl:    mmuOn = value[ctrlMmuEnable];
      cpRegTableIndex: tableIdx = value[3:0];
      cpRegTableEntry: pageMap[tableIdx] = value[3:0];
      default: ;
    endcase
  endtask

  task automatic startFetch(input logic [31:0] addr, input logic abort);
    fetchAddr     = addr;
    fetchExpData  = shadow[physWord(addr)];
    fetchExpAbort = abort;
    fetchExpect   = 1'b1;
    fetchReq      = 1'b1;
  endtask

  task automatic startData(input logic isWrite, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] mask,
                           input logic abort);
    dataWrite    = isWrite;
    dataAddr     = addr;
    dataWdata    = wdata;
    dataMask     = mask;
    dataExpRead  = !isWrite && !abort;
    dataExpData  = shadow[physWord(addr)];
    dataExpAbort = abort;
    dataExpect   = 1'b1;
    dataReq      = 1'b1;
  endtask

  // Operands stay put through the ready cycle, dropped one falling edge later
  task automatic serveRequests();
    logic dataEnd;
    logic fetchEnd;
    dataEnd  = 1'b0;
    fetchEnd = 1'b0;
    while (dataReq || fetchReq) begin
      @(negedge clk);
      if (dataEnd) begin
        dataReq    = 1'b0;
        dataExpect = 1'b0;
      end
      if (fetchEnd) begin
        fetchReq    = 1'b0;
        fetchExpect = 1'b0;
      end
      dataEnd  = dataReq && dataReady;
      fetchEnd = fetchReq && fetchReady;
    end
  endtask

  task automatic applyRow(input rowT row);
    logic [31:0] wdata;
    logic [9:0]  word;
    word  = physWord(row.addr);
    wdata = $random(seed);
    case (row.op)
      opCpWrite: begin
        cpWrEn  = 1'b1;
        cpAddr  = row.addr[3:0];
        cpWdata = row.data;
        trackCpWrite(row.addr[3:0], row.data);
        @(negedge clk);
        cpWrEn = 1'b0;
      end
      opCpRead: begin
        cpAddr    = row.addr[3:0];
        cpExpData = row.data;
        cpExpect  = 1'b1;
        @(negedge clk);
        cpExpect = 1'b0;
      end
      opFetch: begin
        startFetch(row.addr, row.expAbort);
        serveRequests();
      end
      opDataRead, opDataWrite: begin
        startData(row.op == opDataWrite, row.addr, wdata, row.mask, row.expAbort);
        serveRequests();
        // Only unmasked lanes of a completed write change
        if (row.op == opDataWrite && !row.expAbort) begin
          for (int lane = 0; lane < 4; lane++) begin
            if (row.mask[lane])
              shadow[word][lane*8 +: 8] = wdata[lane*8 +: 8];
          end
        end
      end
      opBoth: begin
        startData(1'b0, row.addr, wdata, row.mask, row.expAbort);
        startFetch(row.data, row.expAbort);
        serveRequests();
      end
      default: ;
    endcase
  endtask

  // Run limit scaled to the table length
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Errors: %0d", errors);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    fetchReq     = 1'b0;
    fetchAddr    = '0;
    dataReq      = 1'b0;
    dataWrite    = 1'b0;
    dataAddr     = '0;
    dataWdata    = '0;
    dataMask     = '0;
    cpWrEn       = 1'b0;
    cpAddr       = '0;
    cpWdata      = '0;
    fetchExpect  = 1'b0;
    fetchExpData = '0;
    fetchExpAbort = 1'b0;
    dataExpect   = 1'b0;
    dataExpRead  = 1'b0;
    dataExpData  = '0;
    dataExpAbort = 1'b0;
    cpExpect     = 1'b0;
    cpExpData    = '0;
    mmuOn        = 1'b0;
    tableIdx     = '0;
    for (int i = 0; i < 16; i++)
      pageMap[i] = '0;
    stim = '{
      // Identity mapping, full-word writes then reads from both ports
      '{opDataWrite, 32'h000, 32'h0, 4'hF, 1'b0},
      '{opDataWrite, 32'h104, 32'h0, 4'hF, 1'b0},
      '{opDataWrite, 32'h904, 32'h0, 4'hF, 1'b0},
      '{opDataRead,  32'h000, 32'h0, 4'hF, 1'b0},
      '{opDataRead,  32'h104, 32'h0, 4'hF, 1'b0},
      '{opFetch,     32'h000, 32'h0, 4'hF, 1'b0},
      '{opFetch,     32'h904, 32'h0, 4'hF, 1'b0},
      // Lanes 0 and 2 only
      '{opDataWrite, 32'h104, 32'h0, 4'b0101, 1'b0},
      '{opDataRead,  32'h104, 32'h0, 4'hF, 1'b0},
      '{opFetch,     32'h104, 32'h0, 4'hF, 1'b0},
      // Register readback, page 3 to 9 and page 1 to 1
      '{opCpRead,  32'(cpRegControl),    32'h0,  4'h0, 1'b0},
      '{opCpWrite, 32'(cpRegTableIndex), 32'h3,  4'h0, 1'b0},
      '{opCpRead,  32'(cpRegTableIndex), 32'h3,  4'h0, 1'b0},
      '{opCpWrite, 32'(cpRegTableEntry), 32'h19, 4'h0, 1'b0},
      '{opCpRead,  32'(cpRegTableEntry), 32'h19, 4'h0, 1'b0},
      '{opCpWrite, 32'(cpRegTableIndex), 32'h1,  4'h0, 1'b0},
      '{opCpWrite, 32'(cpRegTableEntry), 32'h11, 4'h0, 1'b0},
      '{opCpRead,  32'h7, 32'h0, 4'h0, 1'b0},
      '{opCpRead,  32'h0, 32'h0, 4'h0, 1'b0},
      '{opCpWrite, 32'(cpRegControl), 32'h1, 4'h0, 1'b0},
      '{opCpRead,  32'(cpRegControl), 32'h1, 4'h0, 1'b0},
      // Translated accesses through virtual page 3
      '{opDataRead,  32'h304, 32'h0, 4'hF, 1'b0},
      '{opFetch,     32'h304, 32'h0, 4'hF, 1'b0},
      '{opDataWrite, 32'h308, 32'h0, 4'hF, 1'b0},
      // Invalid pages abort on the requesting port
      '{opDataRead,  32'h500, 32'h0, 4'hF, 1'b1},
      '{opFetch,     32'h600, 32'h0, 4'hF, 1'b1},
      '{opDataWrite, 32'h000, 32'h0, 4'hF, 1'b1},
      '{opBoth,      32'h304, 32'h104, 4'hF, 1'b0},
      // Back to identity, aborted write must not have landed
      '{opCpWrite, 32'(cpRegControl), 32'h0, 4'h0, 1'b0},
      '{opDataRead,  32'h000, 32'h0, 4'hF, 1'b0},
      '{opDataRead,  32'h908, 32'h0, 4'hF, 1'b0},
      '{opBoth,      32'h000, 32'h904, 4'hF, 1'b0}
    };
    @(posedge rstN);
    for (int r = 0; r < rowCount; r++) begin
      @(negedge clk);
      applyRow(stim[r]);
    end
    repeat (2) @(negedge clk);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== memSubsystem.f ====
logic/memTypesPkg.sv
logic/coprocRegPkg.sv
logic/busArbiter.sv
logic/pageTranslator.sv
logic/coprocRegs.sv
logic/waitStateMemory.sv
logic/memSubsystem.sv
test/clockGen.sv
test/memChecker.sv
test/memSubsystemTb.sv

// ==== Makefile ====
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= memSubsystem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Done: no errors'

clean:
	rm -rf $(OBJ_DIR)
